// ==== Bender.yml ====
package:
  name: soc_ctrl

sources:
  # Packages first, then the RTL from the leaves up
  - verilog/csr_pkg.sv
  - verilog/reset_pkg.sv
  - verilog/reset_timer.sv
  - verilog/reset_sequencer.sv
  - verilog/csr_bridge.sv
  - verilog/sysctl_regs.sv
  - verilog/soc_ctrl_top.sv

  - target: test
    files:
      - verification/tb_soc_ctrl.sv

// ==== list.f ====
verilog/csr_pkg.sv
verilog/reset_pkg.sv
verilog/reset_timer.sv
verilog/reset_sequencer.sv
verilog/csr_bridge.sv
verilog/sysctl_regs.sv
verilog/soc_ctrl_top.sv
verification/tb_soc_ctrl.sv

// ==== verification/soc_ctrl_stim.txt ====
# opcode        address   data      expected   (hex columns)
# set_inputs and expect_irq data: revision in bits 7:4, buttons in bits 2:0
read            0000100c  00000000  10044d31
read            00001010  00000000  00000006
read            0000200c  00000000  00000000
read            0000000c  00000000  00000000
read            00001014  00000000  00000000
read            00001004  00000000  00000000
write           00001004  00000002  00000002
read            00001004  00000000  00000002
set_inputs      00000000  00000053  00000000
read            00001000  00000000  0000002b
write           00001008  00000001  00000002
read            00001008  00000000  00000001
expect_irq      00000000  00000052  00000001
expect_irq      00000000  00000012  00000000
expect_irq      00000000  00000013  00000001
restart_check   00001014  00000001  00000000
read            00001008  00000000  00000000
write           00001004  00000003  00000003
read            00001004  00000000  00000003
restart_check   00000000  00000007  00000000
read            00001000  00000000  0000000b
read            0000100c  00000000  10044d31
expect_irq      00000000  00000012  00000000

// ==== verification/tb_soc_ctrl.sv ====
/*
 * Testbench for the board control core
 * Replays the stimulus file against the DUT and checks reset order,
 * bus latency, GPIO, interrupt and restart behavior
 */
module tb_soc_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	import csr_pkg::*;
	import reset_pkg::*;

	// Byte address of the LED register in the system controller bank
	localparam logic [31:0] GPIO_OUT_ADR =
		32'((SYSCTL_BANK << (CSR_REG_WIDTH + 2)) | (int'(REG_GPIO_OUT) << 2));

	logic sys_clk;
	logic trigger_reset;
	logic [2:0] btn;
	logic [3:0] pcb_rev;
	logic [WB_ADR_WIDTH-1:0] wb_adr;
	logic [DATA_WIDTH-1:0] wb_dat_w;
	logic [DATA_WIDTH-1:0] wb_dat_r;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic [GPIO_OUT_WIDTH-1:0] led;
	logic gpio_irq;
	logic flash_rst_n;
	logic sys_rst;

	// One entry per stimulus line
	string op_q[$];
	logic [31:0] adr_q[$];
	logic [31:0] dat_q[$];
	logic [31:0] exp_q[$];

	int errors;
	int failed_tests;
	int watchdog_cycles;
	logic [2:0] cur_btn;

	soc_ctrl_top u_soc_ctrl_top (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.btn_i          (btn),
		.pcb_revision_i (pcb_rev),
		.wb_adr_i       (wb_adr),
		.wb_dat_i       (wb_dat_w),
		.wb_we_i        (wb_we),
		.wb_cyc_i       (wb_cyc),
		.wb_stb_i       (wb_stb),
		.wb_dat_o       (wb_dat_r),
		.wb_ack_o       (wb_ack),
		.led_o          (led),
		.gpio_irq_o     (gpio_irq),
		.flash_rst_n_o  (flash_rst_n),
		.sys_rst_o      (sys_rst)
	);

	// 8 ns clock
	initial begin
		sys_clk = 1'b0;
		forever begin
			#4 sys_clk = ~sys_clk;
		end
	end

	// ------------------------------------------------------------------------
	// Reporting
	// ------------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name,
			expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		if (errors != err_start) begin
			failed_tests++;
		end
		$display("test %0d %s %s", num, name, (errors == err_start) ? "ok" : "failed");
	endtask

	// ------------------------------------------------------------------------
	// Bus and reset helpers
	// ------------------------------------------------------------------------

	// Single Wishbone access, returns at a falling edge
	task automatic bus_access(input logic we, input logic [31:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int cnt;
		cnt = 0;
		@(posedge sys_clk);
		wb_adr <= adr;
		wb_dat_w <= wdat;
		wb_we <= we;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		// Counted edges include the one that samples the request
		do begin
			@(posedge sys_clk);
			cnt++;
			@(negedge sys_clk);
		end while (wb_ack !== 1'b1 && cnt < 10 * ACK_LATENCY);
		rdat = wb_dat_r;
		if (wb_ack !== 1'b1) begin
			report_failure($sformatf("no ack from DUT for access to address %h", adr));
		end else if (cnt != ACK_LATENCY + 1) begin
			report_mismatch("wb_ack_o latency", ACK_LATENCY + 1, cnt);
		end
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		// Ack must be gone one cycle later
		@(negedge sys_clk);
		if (wb_ack !== 1'b0) begin
			report_mismatch("wb_ack_o width", 0, 32'(wb_ack));
		end
	endtask

	// Called at a falling edge with the flash reset low
	task automatic measure_reset(input int tol);
		int cnt;
		cnt = 0;
		do begin
			@(posedge sys_clk);
			cnt++;
			@(negedge sys_clk);
		end while (flash_rst_n !== 1'b1 && cnt < FLASH_HOLD_CYCLES + 10);
		if (cnt > FLASH_HOLD_CYCLES + tol || cnt < FLASH_HOLD_CYCLES - tol) begin
			report_mismatch("flash_rst_n_o hold cycles", FLASH_HOLD_CYCLES, cnt);
		end
		// System reset trails the flash release
		cnt = 0;
		do begin
			@(posedge sys_clk);
			cnt++;
			@(negedge sys_clk);
		end while (sys_rst !== 1'b0 && cnt < SETTLE_CYCLES + 10);
		if (cnt > SETTLE_CYCLES + tol || cnt < SETTLE_CYCLES - tol) begin
			report_mismatch("sys_rst_o settle cycles", SETTLE_CYCLES, cnt);
		end
	endtask

	// Restart already triggered, wait for it and check the sequence
	task automatic check_restart(input logic [31:0] exp_led);
		int wait_cnt;
		logic [31:0] rdat;
		wait_cnt = 0;
		do begin
			@(negedge sys_clk);
			wait_cnt++;
		end while (flash_rst_n === 1'b1 && wait_cnt < 10);
		if (flash_rst_n !== 1'b0 || sys_rst !== 1'b1) begin
			report_failure("restart did not assert the flash and system resets");
		end else begin
			// Restart lands one edge later than trigger_reset would
			measure_reset(1);
		end
		if (led !== exp_led[GPIO_OUT_WIDTH-1:0]) begin
			report_mismatch("led_o", exp_led, 32'(led));
		end
		bus_access(1'b0, GPIO_OUT_ADR, '0, rdat);
		if (rdat !== exp_led) begin
			report_mismatch("wb_dat_o", exp_led, rdat);
		end
	endtask

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin : main
		int fd;
		int restarts;
		int err_start;
		int pulses;
		string line;
		string op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp_val;
		logic [31:0] rdat;

		errors = 0;
		failed_tests = 0;
		restarts = 0;
		cur_btn = '0;
		trigger_reset = 1'b1;
		btn = '0;
		pcb_rev = '0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;

		// Whole stimulus file up front, comment lines start with #
		fd = $fopen("verification/soc_ctrl_stim.txt", "r");
		if (fd == 0) begin
			report_failure("stimulus file verification/soc_ctrl_stim.txt could not be opened");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#") begin
					if ($sscanf(line, "%s %h %h %h", op, adr, dat, exp_val) == 4) begin
						op_q.push_back(op);
						adr_q.push_back(adr);
						dat_q.push_back(dat);
						exp_q.push_back(exp_val);
						if (op == "restart_check") begin
							restarts++;
						end
					end
				end
			end
			$fclose(fd);
		end

		// One reset length for power-on and each restart, ten ack latencies a line
		watchdog_cycles = (FLASH_HOLD_CYCLES + SETTLE_CYCLES) * (restarts + 1)
			+ op_q.size() * 10 * ACK_LATENCY + 64;

		// Power-on reset order, exact
		err_start = errors;
		repeat (3) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		@(posedge sys_clk);
		@(negedge sys_clk);
		if (flash_rst_n !== 1'b0 || sys_rst !== 1'b1) begin
			report_failure("resets not asserted on the first edge without trigger_reset");
		end
		measure_reset(0);
		report_test(0, "reset_order", err_start);

		foreach (op_q[i]) begin
			err_start = errors;
			adr = adr_q[i];
			dat = dat_q[i];
			exp_val = exp_q[i];
			case (op_q[i])
				"write": begin
					bus_access(1'b1, adr, dat, rdat);
					// Expected column is the LED state after the write
					if (led !== exp_val[GPIO_OUT_WIDTH-1:0]) begin
						report_mismatch("led_o", exp_val, 32'(led));
					end
				end
				"read": begin
					bus_access(1'b0, adr, '0, rdat);
					if (rdat !== exp_val) begin
						report_mismatch("wb_dat_o", exp_val, rdat);
					end
				end
				"set_inputs": begin
					@(posedge sys_clk);
					pcb_rev <= dat[7:4];
					btn <= dat[2:0];
					cur_btn = dat[2:0];
					// Through both synchroniser stages
					repeat (3) @(posedge sys_clk);
				end
				"expect_irq": begin
					@(posedge sys_clk);
					pcb_rev <= dat[7:4];
					btn <= dat[2:0];
					cur_btn = dat[2:0];
					pulses = 0;
					// Cycles with the interrupt high
					repeat (8) begin
						@(negedge sys_clk);
						if (gpio_irq === 1'b1) begin
							pulses++;
						end
					end
					if (pulses != exp_val) begin
						report_mismatch("gpio_irq_o pulses", exp_val, pulses);
					end
				end
				"restart_check": begin
					// Nonzero address is the hard reset register, zero means buttons
					if (adr != '0) begin
						bus_access(1'b1, adr, dat, rdat);
					end else begin
						@(posedge sys_clk);
						btn <= dat[2:0];
						@(posedge sys_clk);
						btn <= cur_btn;
					end
					check_restart(exp_val);
				end
				default: begin
					report_failure($sformatf("unknown opcode %s in stimulus file", op_q[i]));
				end
			endcase
			report_test(i + 1, op_q[i], err_start);
		end

		$display("tests %0d, failed %0d, errors %0d", op_q.size() + 1, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/csr_bridge.sv ====
/*
 * Wishbone to CSR bridge
 * Turns single Wishbone accesses into one-cycle CSR cycles
 * and acks after a fixed latency, reads and writes alike
 */
module csr_bridge (
	input  logic                              sys_clk,
	input  logic                              sys_rst_i,
	input  logic [csr_pkg::WB_ADR_WIDTH-1:0]  wb_adr_i,
	input  logic [csr_pkg::DATA_WIDTH-1:0]    wb_dat_i,
	input  logic                              wb_we_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic [csr_pkg::DATA_WIDTH-1:0]    csr_dr_i,
	output logic [csr_pkg::DATA_WIDTH-1:0]    wb_dat_o,
	output logic                              wb_ack_o,
	output logic [csr_pkg::CSR_ADR_WIDTH-1:0] csr_a_o,
	output logic                              csr_we_o,
	output logic [csr_pkg::DATA_WIDTH-1:0]    csr_dw_o
);
	import csr_pkg::*;

	// 0 idle, 1..ACK_LATENCY counting, ACK_LATENCY+1 waiting for stb low
	logic [ACK_PHASE_WIDTH-1:0] phase_q;
	logic req;
	logic start;
	logic ack_phase;

	assign req = wb_cyc_i & wb_stb_i;
	assign start = (phase_q == '0) && req;
	assign ack_phase = (phase_q == ACK_PHASE_WIDTH'(ACK_LATENCY));

	// ------------------------------------------------------------------------
	// Phase counter and CSR cycle
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			phase_q <= '0;
			wb_ack_o <= 1'b0;
			csr_we_o <= 1'b0;
			csr_a_o <= '0;
		end else begin
			wb_ack_o <= 1'b0;
			// Write strobe lasts the one CSR cycle
			csr_we_o <= 1'b0;
			if (start) begin
				phase_q <= ACK_PHASE_WIDTH'(1);
				// Byte address to CSR word address
				csr_a_o <= wb_adr_i[CSR_ADR_WIDTH+1:2];
				csr_we_o <= wb_we_i;
			end else if (ack_phase) begin
				wb_ack_o <= 1'b1;
				phase_q <= phase_q + 1'b1;
			end else if (phase_q == ACK_PHASE_WIDTH'(ACK_LATENCY + 1)) begin
				// No new access until the master lets go of stb
				if (!wb_stb_i) begin
					phase_q <= '0;
				end
			end else if (phase_q != '0) begin
				phase_q <= phase_q + 1'b1;
			end
		end
	end

	// Write data and read capture
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_dw_o <= wb_dat_i;
		end
		// Bank output is registered and stable by now
		if (ack_phase) begin
			wb_dat_o <= csr_dr_i;
		end
	end

endmodule

// ==== verilog/csr_pkg.sv ====
/*
 * CSR bus and system-controller register map
 * Bus widths, bank layout, fixed identity words and register indices
 */
package csr_pkg;

	// Wishbone side
	localparam int WB_ADR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// CSR word address is bank above register
	localparam int CSR_BANK_WIDTH = 4;
	localparam int CSR_REG_WIDTH = 10;
	localparam int CSR_ADR_WIDTH = CSR_BANK_WIDTH + CSR_REG_WIDTH;
	localparam int SYSCTL_BANK = 1;

	// PCB revision and three buttons in, two LEDs out
	localparam int GPIO_IN_WIDTH = 7;
	localparam int GPIO_OUT_WIDTH = 2;

	// Read-only identity words
	localparam logic [DATA_WIDTH-1:0] SYSTEM_ID = 32'h1004_4D31;
	localparam logic [DATA_WIDTH-1:0] CAPABILITIES = 32'h0000_0006;

	// Edges from accepted request to ack, plus the bridge phase counter size
	localparam int ACK_LATENCY = 3;
	localparam int ACK_PHASE_WIDTH = $clog2(ACK_LATENCY + 2);

	// System-controller register indices
	typedef enum logic [CSR_REG_WIDTH-1:0] {
		REG_GPIO_IN      = 10'd0,
		REG_GPIO_OUT     = 10'd1,
		REG_GPIO_IRQ_EN  = 10'd2,
		REG_SYSTEM_ID    = 10'd3,
		REG_CAPABILITIES = 10'd4,
		REG_HARD_RESET   = 10'd5
	} sysctl_reg_e;

endpackage

// ==== verilog/reset_pkg.sv ====
/*
 * Reset sequence definitions
 * Phase lengths, counter width and sequencer states
 */
package reset_pkg;

	// Flash reset stays asserted this long after the reset request ends
	localparam int FLASH_HOLD_CYCLES = 128;

	// System reset trails the flash release by this much
	// Short stand-in for the board debounce delay
	localparam int SETTLE_CYCLES = 256;

	// Wide enough for the longer phase
	localparam int TIMER_WIDTH = 9;

	// Sequencer states
	// FLASH_HOLD  both resets asserted
	// SETTLE      flash running, system still held
	// RUN         everything released
	typedef enum logic [1:0] {
		FLASH_HOLD,
		SETTLE,
		RUN
	} seq_state_e;

endpackage

// ==== verilog/reset_sequencer.sv ====
/*
 * Reset sequencer
 * Merges external, button and software resets, then releases
 * the flash reset first and the system reset after a settle time
 */
module reset_sequencer (
	input  logic                              sys_clk,
	input  logic                              trigger_reset,
	input  logic [2:0]                        btn_i,
	input  logic                              hard_reset_req_i,
	input  logic                              timer_expired_i,
	output logic                              timer_load_o,
	output logic [reset_pkg::TIMER_WIDTH-1:0] timer_value_o,
	output logic                              flash_rst_n_o,
	output logic                              sys_rst_o
);
	import reset_pkg::*;

	seq_state_e state_q;
	seq_state_e state_d;
	logic restart_q;
	logic seq_rst;
	logic load_d;
	logic [TIMER_WIDTH-1:0] value_d;

	// Three-button chord or software request
	// Registered, so it lands one edge late
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			restart_q <= 1'b0;
		end else begin
			restart_q <= (&btn_i) | hard_reset_req_i;
		end
	end

	assign seq_rst = trigger_reset | restart_q;

	// ------------------------------------------------------------------------
	// Next state and timer programming
	// ------------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		load_d = 1'b0;
		value_d = timer_value_o;
		if (seq_rst) begin
			// Load lands on the first edge after the request drops
			state_d = FLASH_HOLD;
			load_d = 1'b1;
			value_d = TIMER_WIDTH'(FLASH_HOLD_CYCLES - 1);
		end else begin
			case (state_q)
				FLASH_HOLD: begin
					if (timer_expired_i) begin
						state_d = SETTLE;
						load_d = 1'b1;
						// One edge to load, one to see expiry
						value_d = TIMER_WIDTH'(SETTLE_CYCLES - 2);
					end
				end
				SETTLE: begin
					if (timer_expired_i) begin
						state_d = RUN;
					end
				end
				default: begin
					state_d = RUN;
				end
			endcase
		end
	end

	// Outputs decoded from the next state so they move with state_q
	always_ff @(posedge sys_clk) begin
		state_q <= state_d;
		timer_load_o <= load_d;
		timer_value_o <= value_d;
		flash_rst_n_o <= (state_d != FLASH_HOLD);
		sys_rst_o <= (state_d != RUN);
	end

endmodule

// ==== verilog/reset_timer.sv ====
/*
 * Reset phase timer
 * Loadable down-counter that stops at zero
 */
module reset_timer (
	input  logic                              sys_clk,
	input  logic                              trigger_reset,
	input  logic                              load_i,
	input  logic [reset_pkg::TIMER_WIDTH-1:0] value_i,
	output logic                              expired_o
);
	import reset_pkg::*;

	logic [TIMER_WIDTH-1:0] count_q;

	// Load wins over counting
	// Count parks at zero until the next load
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= value_i;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	// A pending load hides the stale zero of the previous phase
	assign expired_o = (count_q == '0) && !load_i;

endmodule

// ==== verilog/soc_ctrl_top.sv ====
/*
 * Board control core
 * Reset generation plus the Wishbone path into the system controller
 */
module soc_ctrl_top (
	input  logic                               sys_clk,
	input  logic                               trigger_reset,
	input  logic [2:0]                         btn_i,
	input  logic [3:0]                         pcb_revision_i,
	input  logic [csr_pkg::WB_ADR_WIDTH-1:0]   wb_adr_i,
	input  logic [csr_pkg::DATA_WIDTH-1:0]     wb_dat_i,
	input  logic                               wb_we_i,
	input  logic                               wb_cyc_i,
	input  logic                               wb_stb_i,
	output logic [csr_pkg::DATA_WIDTH-1:0]     wb_dat_o,
	output logic                               wb_ack_o,
	output logic [csr_pkg::GPIO_OUT_WIDTH-1:0] led_o,
	output logic                               gpio_irq_o,
	output logic                               flash_rst_n_o,
	output logic                               sys_rst_o
);
	import csr_pkg::*;
	import reset_pkg::*;

	// ------------------------------------------------------------------------
	// Reset core
	// ------------------------------------------------------------------------
	logic timer_load;
	logic [TIMER_WIDTH-1:0] timer_value;
	logic timer_expired;
	logic hard_reset_req;

	reset_sequencer u_reset_sequencer (
		.sys_clk          (sys_clk),
		.trigger_reset    (trigger_reset),
		.btn_i            (btn_i),
		.hard_reset_req_i (hard_reset_req),
		.timer_expired_i  (timer_expired),
		.timer_load_o     (timer_load),
		.timer_value_o    (timer_value),
		.flash_rst_n_o    (flash_rst_n_o),
		.sys_rst_o        (sys_rst_o)
	);

	reset_timer u_reset_timer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.load_i        (timer_load),
		.value_i       (timer_value),
		.expired_o     (timer_expired)
	);

	// ------------------------------------------------------------------------
	// CSR bus
	// ------------------------------------------------------------------------
	logic [CSR_ADR_WIDTH-1:0] csr_a;
	logic csr_we;
	logic [DATA_WIDTH-1:0] csr_dw;
	logic [DATA_WIDTH-1:0] csr_dr;

	csr_bridge u_csr_bridge (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_o),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.csr_dr_i  (csr_dr),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw)
	);

	// GPIO input word has the revision above buttons 3..1
	sysctl_regs u_sysctl_regs (
		.sys_clk          (sys_clk),
		.sys_rst_i        (sys_rst_o),
		.csr_a_i          (csr_a),
		.csr_we_i         (csr_we),
		.csr_di_i         (csr_dw),
		.csr_do_o         (csr_dr),
		.gpio_irq_o       (gpio_irq_o),
		.gpio_in_i        ({pcb_revision_i, btn_i}),
		.gpio_out_o       (led_o),
		.hard_reset_req_o (hard_reset_req)
	);

endmodule

// ==== verilog/sysctl_regs.sv ====
/*
 * System controller CSR bank
 * GPIO inputs and LED outputs, GPIO change interrupt,
 * system ID and capability words, software hard reset
 */
module sysctl_regs (
	input  logic                               sys_clk,
	input  logic                               sys_rst_i,
	input  logic [csr_pkg::CSR_ADR_WIDTH-1:0]  csr_a_i,
	input  logic                               csr_we_i,
	input  logic [csr_pkg::DATA_WIDTH-1:0]     csr_di_i,
	output logic [csr_pkg::DATA_WIDTH-1:0]     csr_do_o,
	output logic                               gpio_irq_o,
	input  logic [csr_pkg::GPIO_IN_WIDTH-1:0]  gpio_in_i,
	output logic [csr_pkg::GPIO_OUT_WIDTH-1:0] gpio_out_o,
	output logic                               hard_reset_req_o
);
	import csr_pkg::*;

	logic sel;
	sysctl_reg_e reg_idx;
	logic [GPIO_IN_WIDTH-1:0] gpio_meta_q;
	logic [GPIO_IN_WIDTH-1:0] gpio_sync_q;
	logic [GPIO_IN_WIDTH-1:0] gpio_prev_q;
	logic [GPIO_IN_WIDTH-1:0] gpio_irq_en_q;

	// Bank select and register index
	assign sel = (csr_a_i[CSR_ADR_WIDTH-1:CSR_REG_WIDTH] == CSR_BANK_WIDTH'(SYSCTL_BANK));
	assign reg_idx = sysctl_reg_e'(csr_a_i[CSR_REG_WIDTH-1:0]);

	// ------------------------------------------------------------------------
	// GPIO input synchroniser and change history
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta_q <= gpio_in_i;
		gpio_sync_q <= gpio_meta_q;
		gpio_prev_q <= gpio_sync_q;
	end

	// ------------------------------------------------------------------------
	// Control registers, interrupt and hard reset
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			gpio_irq_en_q <= '0;
			gpio_irq_o <= 1'b0;
			hard_reset_req_o <= 1'b0;
		end else begin
			// Pulse on any enabled input edge, either direction
			gpio_irq_o <= |((gpio_sync_q ^ gpio_prev_q) & gpio_irq_en_q);
			hard_reset_req_o <= 1'b0;
			if (sel && csr_we_i) begin
				case (reg_idx)
					REG_GPIO_OUT:    gpio_out_o <= csr_di_i[GPIO_OUT_WIDTH-1:0];
					REG_GPIO_IRQ_EN: gpio_irq_en_q <= csr_di_i[GPIO_IN_WIDTH-1:0];
					REG_HARD_RESET:  hard_reset_req_o <= csr_di_i[0];
					default: ;
				endcase
			end
		end
	end

	// Registered read mux, zero when another bank is addressed
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (sel) begin
				case (reg_idx)
					REG_GPIO_IN:      csr_do_o <= DATA_WIDTH'(gpio_sync_q);
					REG_GPIO_OUT:     csr_do_o <= DATA_WIDTH'(gpio_out_o);
					REG_GPIO_IRQ_EN:  csr_do_o <= DATA_WIDTH'(gpio_irq_en_q);
					REG_SYSTEM_ID:    csr_do_o <= SYSTEM_ID;
					REG_CAPABILITIES: csr_do_o <= CAPABILITIES;
					// Hard reset is write-only
					default:          csr_do_o <= '0;
				endcase
			end
		end
	end

endmodule
